//--- common/colourMemoryPkg.sv
// Shared geometry, game limits, colours and types for the ColourMemory core; referenced by scope.
package colourMemoryPkg;

    // ******************************
    // Screen geometry
    // ******************************

    localparam int unsigned screenWidth  = 240;
    localparam int unsigned screenHeight = 320;

    // Column and row address types.
    typedef logic [7:0] xAddrT;
    typedef logic [8:0] yAddrT;

    // ******************************
    // Game limits
    // ******************************

    // Longest sequence, and the sequence length at level 1.
    localparam int unsigned maxSeqLength     = 31;
    localparam int unsigned initialSeqLength = 3;

    // Cycles in each flash or gap phase, minus one.
    localparam int unsigned flashCycles = 16;

    typedef logic [4:0] seqLenT;
    typedef logic [6:0] scoreT;

    // ******************************
    // Colours and keys
    // ******************************

    // One-hot key colours: bit 0 green, 1 red, 2 blue, 3 yellow.
    typedef logic [3:0]  keyT;
    typedef logic [15:0] rgbT;

    // RGB565 values.
    localparam rgbT colourBlack    = 16'h0000;
    localparam rgbT colourGreen    = 16'h4DC4;
    localparam rgbT colourRed      = 16'hF920;
    localparam rgbT colourBlue     = 16'h24F7;
    localparam rgbT colourYellow   = 16'hFDA0;
    localparam rgbT colourIntro    = 16'hFFFF;
    localparam rgbT colourWin      = 16'h07FF;
    localparam rgbT colourGameOver = 16'hF81F;

    // Game-over banner region, exclusive of top and left edges.
    localparam int unsigned bannerTop    = 142;
    localparam int unsigned bannerBottom = 178;
    localparam int unsigned bannerLeft   = 23;
    localparam int unsigned bannerRight  = 218;

    // ******************************
    // Types
    // ******************************

    // What the composer should draw.
    typedef enum logic [2:0] {
        codeBlack, codeGreen, codeRed, codeBlue,
        codeYellow, codeIntro, codeWin, codeGameOver
    } screenCodeT;

    // Game controller states.
    typedef enum logic [2:0] {
        stIntro, stSeqGen, stMemorise, stPlay,
        stWin, stGameOver, stKeyHeld
    } gameStateT;

    // Pixel stream towards the display driver.
    typedef struct packed {
        xAddrT xAddr;
        yAddrT yAddr;
        rgbT   pixelData;
        logic  pixelWrite;
    } pixelStreamT;

endpackage

//--- hdl/rasterScanner.sv
// Raster address walk for the pixel stream; steps one pixel per cycle while the display is ready.
`timescale 1ns/1ps

module rasterScanner (
    input  logic                 clock,
    input  logic                 resetApp,
    input  logic                 pixelReady,
    output colourMemoryPkg::xAddrT xAddr,
    output colourMemoryPkg::yAddrT yAddr,
    output logic                 pixelWrite
);

    // End-of-line and end-of-frame flags.
    logic lastColumn;
    logic lastRow;

    assign lastColumn = (xAddr == colourMemoryPkg::xAddrT'(colourMemoryPkg::screenWidth - 1));
    assign lastRow    = (yAddr == colourMemoryPkg::yAddrT'(colourMemoryPkg::screenHeight - 1));

    // Column and row counters.
    // Hold while the display is busy.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            xAddr <= '0;
            yAddr <= '0;
        end else if (pixelReady) begin
            if (lastColumn) begin
                xAddr <= '0;
                // Next row, or back to the top.
                if (lastRow) begin
                    yAddr <= '0;
                end else begin
                    yAddr <= yAddr + 1'b1;
                end
            end else begin
                xAddr <= xAddr + 1'b1;
            end
        end
    end

    // Write level.
    // Low in reset, then always writing.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            pixelWrite <= 1'b0;
        end else begin
            pixelWrite <= 1'b1;
        end
    end

endmodule

//--- game/gameController.sv
// Game FSM for ColourMemory: key filter, sequence store, flash timing, scoring and screen codes.
`timescale 1ns/1ps

module gameController (
    input  logic                        clock,
    input  logic                        resetApp,
    input  colourMemoryPkg::keyT        nKey,
    output colourMemoryPkg::screenCodeT screenCode,
    output colourMemoryPkg::scoreT      score,
    output logic                        scoreVisible
);

    // ******************************
    // Key filter
    // ******************************

    colourMemoryPkg::keyT rawKey;
    colourMemoryPkg::keyT key;

    // Active high, then only patterns with one bit set survive.
    assign rawKey = ~nKey;
    assign key    = (rawKey != '0 && (rawKey & (rawKey - 1'b1)) == '0) ? rawKey : '0;

    // ******************************
    // Random sequence source
    // ******************************

    logic [31:0]          cycleCount;
    logic [31:0]          shiftedCount;
    colourMemoryPkg::keyT randomKey;

    colourMemoryPkg::gameStateT state;
    colourMemoryPkg::gameStateT returnState;
    colourMemoryPkg::seqLenT    seqLength;
    colourMemoryPkg::seqLenT    seqIndex;
    colourMemoryPkg::keyT       seqStore [colourMemoryPkg::maxSeqLength];

    // Flash phase timer and colour/gap toggle.
    logic [$clog2(colourMemoryPkg::flashCycles + 1) - 1:0] flashTimer;
    logic                                                    showColour;
    logic                                                    phaseDone;

    // Free-running count, timing of the player makes it random enough.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            cycleCount <= '0;
        end else begin
            cycleCount <= cycleCount + 1'b1;
        end
    end

    // Two bits picked by the index, decoded one-hot.
    assign shiftedCount = cycleCount >> seqIndex;
    assign randomKey    = colourMemoryPkg::keyT'(4'b0001 << shiftedCount[1:0]);

    // Sequence store.
    // One entry written per cycle of sequence generation.
    always_ff @(posedge clock) begin
        if (state == colourMemoryPkg::stSeqGen) begin
            seqStore[seqIndex] <= randomKey;
        end
    end

    assign phaseDone = (flashTimer == ($bits(flashTimer))'(colourMemoryPkg::flashCycles));

    // Score shows only on the result screens.
    assign scoreVisible = (state == colourMemoryPkg::stWin) ||
                          (state == colourMemoryPkg::stGameOver);

    // Screen code for a one-hot key colour.
    function automatic colourMemoryPkg::screenCodeT keyToCode(input colourMemoryPkg::keyT k);
        case (k)
            4'b0001: keyToCode = colourMemoryPkg::codeGreen;
            4'b0010: keyToCode = colourMemoryPkg::codeRed;
            4'b0100: keyToCode = colourMemoryPkg::codeBlue;
            4'b1000: keyToCode = colourMemoryPkg::codeYellow;
            default: keyToCode = colourMemoryPkg::codeBlack;
        endcase
    endfunction

    // ******************************
    // Game state machine
    // ******************************

    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            state       <= colourMemoryPkg::stIntro;
            returnState <= colourMemoryPkg::stIntro;
            seqLength   <= colourMemoryPkg::seqLenT'(colourMemoryPkg::initialSeqLength);
            seqIndex    <= '0;
            score       <= '0;
            flashTimer  <= '0;
            showColour  <= 1'b0;
            screenCode  <= colourMemoryPkg::codeIntro;
        end else begin
            case (state)
                // New game on any single key.
                colourMemoryPkg::stIntro: begin
                    seqLength  <= colourMemoryPkg::seqLenT'(colourMemoryPkg::initialSeqLength);
                    seqIndex   <= '0;
                    score      <= '0;
                    screenCode <= colourMemoryPkg::codeIntro;
                    if (key != '0) begin
                        returnState <= colourMemoryPkg::stSeqGen;
                        state       <= colourMemoryPkg::stKeyHeld;
                    end
                end

                // One entry per cycle, black screen meanwhile.
                colourMemoryPkg::stSeqGen: begin
                    screenCode <= colourMemoryPkg::codeBlack;
                    if (seqIndex + 1'b1 == seqLength) begin
                        seqIndex   <= '0;
                        flashTimer <= '0;
                        showColour <= 1'b0;
                        state      <= colourMemoryPkg::stMemorise;
                    end else begin
                        seqIndex <= seqIndex + 1'b1;
                    end
                end

                // Black gap, then the colour, for every entry.
                colourMemoryPkg::stMemorise: begin
                    if (!phaseDone) begin
                        flashTimer <= flashTimer + 1'b1;
                    end else begin
                        flashTimer <= '0;
                        showColour <= ~showColour;
                        if (!showColour) begin
                            screenCode <= keyToCode(seqStore[seqIndex]);
                        end else begin
                            screenCode <= colourMemoryPkg::codeBlack;
                            // Last colour done, hand over to the player.
                            if (seqIndex + 1'b1 == seqLength) begin
                                seqIndex <= '0;
                                state    <= colourMemoryPkg::stPlay;
                            end else begin
                                seqIndex <= seqIndex + 1'b1;
                            end
                        end
                    end
                end

                // Check each press, echo its colour.
                colourMemoryPkg::stPlay: begin
                    if (key != '0) begin
                        screenCode <= keyToCode(key);
                        state      <= colourMemoryPkg::stKeyHeld;
                        if (key == seqStore[seqIndex]) begin
                            score    <= score + 1'b1;
                            seqIndex <= seqIndex + 1'b1;
                            if (seqIndex + 1'b1 == seqLength) begin
                                returnState <= colourMemoryPkg::stWin;
                            end else begin
                                returnState <= colourMemoryPkg::stPlay;
                            end
                        end else begin
                            returnState <= colourMemoryPkg::stGameOver;
                        end
                    end
                end

                // Level complete; grow the length up to the limit.
                colourMemoryPkg::stWin: begin
                    screenCode <= colourMemoryPkg::codeWin;
                    if (key != '0) begin
                        if (seqLength != colourMemoryPkg::seqLenT'(colourMemoryPkg::maxSeqLength)) begin
                            seqLength <= seqLength + 1'b1;
                        end
                        seqIndex    <= '0;
                        returnState <= colourMemoryPkg::stSeqGen;
                        state       <= colourMemoryPkg::stKeyHeld;
                    end
                end

                // Banner until any key.
                colourMemoryPkg::stGameOver: begin
                    screenCode <= colourMemoryPkg::codeGameOver;
                    if (key != '0) begin
                        returnState <= colourMemoryPkg::stIntro;
                        state       <= colourMemoryPkg::stKeyHeld;
                    end
                end

                // Wait for release.
                colourMemoryPkg::stKeyHeld: begin
                    if (key == '0) begin
                        state <= returnState;
                    end
                end

                default: begin
                    state <= colourMemoryPkg::stIntro;
                end
            endcase
        end
    end

endmodule

//--- hdl/pixelComposer.sv
// Pixel colour generator; maps the screen code and raster address to a registered RGB565 word.
`timescale 1ns/1ps

module pixelComposer (
    input  logic                        clock,
    input  logic                        resetApp,
    input  colourMemoryPkg::screenCodeT screenCode,
    input  colourMemoryPkg::xAddrT      xAddr,
    input  colourMemoryPkg::yAddrT      yAddr,
    output colourMemoryPkg::rgbT        pixelData
);

    // Address falls in the game-over banner.
    logic inBanner;

    assign inBanner = (yAddr >  colourMemoryPkg::yAddrT'(colourMemoryPkg::bannerTop))    &&
                      (yAddr <= colourMemoryPkg::yAddrT'(colourMemoryPkg::bannerBottom)) &&
                      (xAddr >  colourMemoryPkg::xAddrT'(colourMemoryPkg::bannerLeft))   &&
                      (xAddr <= colourMemoryPkg::xAddrT'(colourMemoryPkg::bannerRight));

    // ******************************
    // Colour select
    // ******************************

    // One cycle from code and address to pixel.
    always_ff @(posedge clock or posedge resetApp) begin
        if (resetApp) begin
            pixelData <= colourMemoryPkg::colourBlack;
        end else begin
            case (screenCode)
                colourMemoryPkg::codeGreen:  pixelData <= colourMemoryPkg::colourGreen;
                colourMemoryPkg::codeRed:    pixelData <= colourMemoryPkg::colourRed;
                colourMemoryPkg::codeBlue:   pixelData <= colourMemoryPkg::colourBlue;
                colourMemoryPkg::codeYellow: pixelData <= colourMemoryPkg::colourYellow;
                colourMemoryPkg::codeIntro:  pixelData <= colourMemoryPkg::colourIntro;
                colourMemoryPkg::codeWin:    pixelData <= colourMemoryPkg::colourWin;
                // Solid banner on black.
                colourMemoryPkg::codeGameOver: begin
                    if (inBanner) begin
                        pixelData <= colourMemoryPkg::colourGameOver;
                    end else begin
                        pixelData <= colourMemoryPkg::colourBlack;
                    end
                end
                default: pixelData <= colourMemoryPkg::colourBlack;
            endcase
        end
    end

endmodule

//--- hdl/scoreDisplay.sv
// Score readout; drives two active-low decimal seven-segment digits, blank when hidden or over 99.
`timescale 1ns/1ps

module scoreDisplay (
    input  colourMemoryPkg::scoreT score,
    input  logic                   scoreVisible,
    output logic [6:0]             nSevenSeg0,
    output logic [6:0]             nSevenSeg1
);

    // Decimal digits of the score.
    colourMemoryPkg::scoreT tensValue;
    colourMemoryPkg::scoreT unitsValue;
    logic                   blank;

    assign tensValue  = score / 7'd10;
    assign unitsValue = score % 7'd10;
    assign blank      = !scoreVisible || (score > 7'd99);

    // Segments for one digit.
    // Bit order is g down to a, active high here.
    function automatic logic [6:0] segEncode(input logic [3:0] digit);
        case (digit)
            4'd0:    segEncode = 7'h3F;
            4'd1:    segEncode = 7'h06;
            4'd2:    segEncode = 7'h5B;
            4'd3:    segEncode = 7'h4F;
            4'd4:    segEncode = 7'h66;
            4'd5:    segEncode = 7'h6D;
            4'd6:    segEncode = 7'h7D;
            4'd7:    segEncode = 7'h07;
            4'd8:    segEncode = 7'h7F;
            4'd9:    segEncode = 7'h6F;
            default: segEncode = 7'h00;
        endcase
    endfunction

    // ******************************
    // Output drive
    // ******************************

    // Active-low pins, all ones is dark.
    always_comb begin
        if (blank) begin
            nSevenSeg0 = 7'h7F;
            nSevenSeg1 = 7'h7F;
        end else begin
            nSevenSeg0 = ~segEncode(unitsValue[3:0]);
            nSevenSeg1 = ~segEncode(tensValue[3:0]);
        end
    end

endmodule

//--- hdl/colourMemoryTop.sv
// ColourMemory top level; joins scanner, game, composer and score readout into the pixel stream.
`timescale 1ns/1ps

module colourMemoryTop (
    input  logic                         clock,
    input  logic                         resetApp,
    input  colourMemoryPkg::keyT         nKey,
    input  logic                         pixelReady,
    output colourMemoryPkg::pixelStreamT pixelStream,
    output logic [6:0]                   nSevenSeg0,
    output logic [6:0]                   nSevenSeg1
);

    // Scanner position and write level.
    colourMemoryPkg::xAddrT      xAddr;
    colourMemoryPkg::yAddrT      yAddr;
    logic                        pixelWrite;
    // Game outputs.
    colourMemoryPkg::screenCodeT screenCode;
    colourMemoryPkg::scoreT      score;
    logic                        scoreVisible;
    colourMemoryPkg::rgbT        pixelData;

    rasterScanner rasterScanner_inst (
        .clock     (clock),
        .resetApp  (resetApp),
        .pixelReady(pixelReady),
        .xAddr     (xAddr),
        .yAddr     (yAddr),
        .pixelWrite(pixelWrite)
    );

    gameController gameController_inst (
        .clock       (clock),
        .resetApp    (resetApp),
        .nKey        (nKey),
        .screenCode  (screenCode),
        .score       (score),
        .scoreVisible(scoreVisible)
    );

    pixelComposer pixelComposer_inst (
        .clock     (clock),
        .resetApp  (resetApp),
        .screenCode(screenCode),
        .xAddr     (xAddr),
        .yAddr     (yAddr),
        .pixelData (pixelData)
    );

    scoreDisplay scoreDisplay_inst (
        .score       (score),
        .scoreVisible(scoreVisible),
        .nSevenSeg0  (nSevenSeg0),
        .nSevenSeg1  (nSevenSeg1)
    );

    // Stream bundle to the display driver.
    assign pixelStream = '{xAddr: xAddr, yAddr: yAddr, pixelData: pixelData,
                           pixelWrite: pixelWrite};

endmodule

//--- tests/colourMemoryTb.sv
// Testbench for the ColourMemory core; plays the game through the top level and checks stream and digits.
`timescale 1ns/1ps

module colourMemoryTb;

    // ******************************
    // Limits and signals
    // ******************************

    localparam int frameCycles = colourMemoryPkg::screenWidth * colourMemoryPkg::screenHeight;
    // Flash and gap phases over levels 1 to 3.
    localparam int flashPhases = 2 * (3 + 4 + 5);
    // Two raster frames are walked as well.
    localparam int timeoutCycles = flashPhases * (colourMemoryPkg::flashCycles + 1)
                                   + 2 * frameCycles + 10000;

    logic                         clock;
    logic                         resetApp;
    colourMemoryPkg::keyT         nKey;
    logic                         pixelReady;
    colourMemoryPkg::pixelStreamT pixelStream;
    logic [6:0]                   nSevenSeg0;
    logic [6:0]                   nSevenSeg1;

    // What the checker expects right now.
    logic                        checkPixels = 1'b0;
    logic                        checkSegs = 1'b0;
    colourMemoryPkg::screenCodeT expectCode = colourMemoryPkg::codeIntro;
    int                          expectScore = 0;
    logic                        expectVisible = 1'b0;
    logic                        readyRandom = 1'b0;
    logic [15:0]                 lfsrState = 16'd39;

    // Address seen on the previous rising edge.
    colourMemoryPkg::xAddrT prevX;
    colourMemoryPkg::yAddrT prevY;
    logic                   prevReady;
    logic                   prevValid = 1'b0;

    int stimErrors = 0;
    int compareErrors = 0;
    int holdCount = 0;
    int colWrapCount = 0;
    int frameWrapCount = 0;
    int bannerCount = 0;
    int outsideCount = 0;
    int testsRun = 0;
    int testsFailed = 0;
    int cycleCount = 0;

    // Colours seen by the player during memorisation.
    colourMemoryPkg::rgbT seqColours[$];

    colourMemoryTop colourMemoryTop_inst (
        .clock      (clock),
        .resetApp   (resetApp),
        .nKey       (nKey),
        .pixelReady (pixelReady),
        .pixelStream(pixelStream),
        .nSevenSeg0 (nSevenSeg0),
        .nSevenSeg1 (nSevenSeg1)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    // ******************************
    // Reference functions
    // ******************************

    // Fibonacci LFSR, taps 16 14 13 11.
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        lfsrNext = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Solid colours, or the banner rule on the game-over screen.
    function automatic colourMemoryPkg::rgbT expectedPixel(
        input colourMemoryPkg::screenCodeT code, input int x, input int y);
        logic inBanner;
        inBanner = y > 142 && y <= 178 && x > 23 && x <= 218;
        case (code)
            colourMemoryPkg::codeGreen:    expectedPixel = 16'h4DC4;
            colourMemoryPkg::codeRed:      expectedPixel = 16'hF920;
            colourMemoryPkg::codeBlue:     expectedPixel = 16'h24F7;
            colourMemoryPkg::codeYellow:   expectedPixel = 16'hFDA0;
            colourMemoryPkg::codeIntro:    expectedPixel = 16'hFFFF;
            colourMemoryPkg::codeWin:      expectedPixel = 16'h07FF;
            colourMemoryPkg::codeGameOver: expectedPixel = inBanner ? 16'hF81F : 16'h0000;
            default:                       expectedPixel = 16'h0000;
        endcase
    endfunction

    // Active-low glyphs, gfedcba; tens digit in the upper half.
    function automatic logic [13:0] expectedSegments(input int value, input logic visible);
        logic [6:0] glyph [10];
        glyph = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10};
        if (!visible || value > 99) begin
            expectedSegments = 14'h3FFF;
        end else begin
            expectedSegments = {glyph[value / 10], glyph[value % 10]};
        end
    endfunction

    // Column first, then row; hold when not ready.
    function automatic logic [16:0] nextAddress(input int x, input int y, input logic ready);
        if (!ready) begin
            nextAddress = {8'(x), 9'(y)};
        end else if (x < 239) begin
            nextAddress = {8'(x + 1), 9'(y)};
        end else if (y < 319) begin
            nextAddress = {8'd0, 9'(y + 1)};
        end else begin
            nextAddress = '0;
        end
    endfunction

    function automatic colourMemoryPkg::keyT colourToKey(input colourMemoryPkg::rgbT colour);
        case (colour)
            16'h4DC4: colourToKey = 4'b0001;
            16'hF920: colourToKey = 4'b0010;
            16'h24F7: colourToKey = 4'b0100;
            16'hFDA0: colourToKey = 4'b1000;
            default:  colourToKey = 4'b0000;
        endcase
    endfunction

    function automatic int totalErrors();
        totalErrors = stimErrors + compareErrors;
    endfunction

    // ******************************
    // Comparing process
    // ******************************

    // DUT outputs change only through nonblocking updates, so pre-edge values are read here.
    always @(posedge clock) begin : compare
        logic [16:0]          expectAddr;
        logic [13:0]          expectSeg;
        colourMemoryPkg::rgbT expectPix;
        if (resetApp) begin
            prevValid = 1'b0;
        end else begin
            if (prevValid) begin
                expectAddr = nextAddress(int'(prevX), int'(prevY), prevReady);
                assert ({pixelStream.xAddr, pixelStream.yAddr} == expectAddr) else begin
                    $display("[FAIL] xAddr/yAddr expected 0x%h/0x%h got 0x%h/0x%h",
                             expectAddr[16:9], expectAddr[8:0],
                             pixelStream.xAddr, pixelStream.yAddr);
                    compareErrors++;
                end
                // A stall only counts when the address really held.
                if (!prevReady && pixelStream.xAddr == prevX && pixelStream.yAddr == prevY) begin
                    holdCount++;
                end
                if (prevReady && prevX == 8'd239) colWrapCount++;
                if (prevReady && prevX == 8'd239 && prevY == 9'd319) frameWrapCount++;
                // Pixel word lags the address by one edge.
                if (checkPixels) begin
                    expectPix = expectedPixel(expectCode, int'(prevX), int'(prevY));
                    assert (pixelStream.pixelData == expectPix) else begin
                        $display("[FAIL] pixelData expected 0x%h got 0x%h",
                                 expectPix, pixelStream.pixelData);
                        compareErrors++;
                    end
                    if (expectPix == 16'hF81F) bannerCount++;
                    else if (expectCode == colourMemoryPkg::codeGameOver) outsideCount++;
                end
            end
            if (checkSegs) begin
                expectSeg = expectedSegments(expectScore, expectVisible);
                assert ({nSevenSeg1, nSevenSeg0} == expectSeg) else begin
                    $display("[FAIL] nSevenSeg1/nSevenSeg0 expected 0x%h got 0x%h",
                             expectSeg, {nSevenSeg1, nSevenSeg0});
                    compareErrors++;
                end
            end
            prevX     = pixelStream.xAddr;
            prevY     = pixelStream.yAddr;
            prevReady = pixelReady;
            prevValid = 1'b1;
        end
    end

    // Run limit.
    initial begin : watchdog
        while (cycleCount < timeoutCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the game never reached the awaited screen",
                 cycleCount);
        $display("=== FAIL ===");
        $finish;
    end

    // ******************************
    // Stimulus and player model
    // ******************************

    task automatic drawBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | int'(lfsrState[0]);
        end
    endtask

    // One falling edge; new ready level.
    task automatic stepCycle();
        int bitValue;
        @(negedge clock);
        if (readyRandom) begin
            drawBits(1, bitValue);
            pixelReady = bitValue[0];
        end else begin
            pixelReady = 1'b1;
        end
    endtask

    task automatic stepCycles(input int count);
        repeat (count) stepCycle();
    endtask

    task automatic waitColour(input colourMemoryPkg::rgbT colour);
        while (pixelStream.pixelData != colour) stepCycle();
    endtask

    // Press for 1 to 4 cycles, release for 1 to 4.
    task automatic pressKey(input colourMemoryPkg::keyT keys);
        int hold;
        int gap;
        drawBits(2, hold);
        drawBits(2, gap);
        stepCycle();
        nKey = ~keys;
        stepCycles(hold + 1);
        nKey = 4'hF;
        stepCycles(gap + 1);
    endtask

    // Check a steady screen for a few cycles.
    task automatic holdScreen(input colourMemoryPkg::screenCodeT code, input int value,
                              input logic visible, input int cycles);
        expectCode    = code;
        expectScore   = value;
        expectVisible = visible;
        checkPixels   = 1'b1;
        checkSegs     = 1'b1;
        stepCycles(cycles);
        checkPixels   = 1'b0;
        checkSegs     = 1'b0;
    endtask

    // Non-black runs after the black of sequence generation.
    task automatic collectRuns(input int count);
        colourMemoryPkg::rgbT colour;
        seqColours.delete();
        waitColour(16'h0000);
        while (seqColours.size() < count) begin
            stepCycle();
            colour = pixelStream.pixelData;
            if (colour != 16'h0000) begin
                assert (colourToKey(colour) != 4'b0000) else begin
                    $display("[FAIL] pixelData expected a key colour got 0x%h", colour);
                    stimErrors++;
                end
                seqColours.push_back(colour);
                waitColour(16'h0000);
            end
        end
    endtask

    task automatic replaySequence();
        foreach (seqColours[i]) begin
            pressKey(colourToKey(seqColours[i]));
        end
    endtask

    // Digits light on the result screen; the colour follows two edges later.
    task automatic checkWin(input int value);
        while (nSevenSeg0 == 7'h7F) stepCycle();
        stepCycles(3);
        holdScreen(colourMemoryPkg::codeWin, value, 1'b1, 6);
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        testsRun++;
        if (totalErrors() == errorsBefore) begin
            $display("Test %0d %s: passed", testsRun, name);
        end else begin
            testsFailed++;
            $display("Test %0d %s: failed with %0d errors", testsRun, name,
                     totalErrors() - errorsBefore);
        end
    endtask

    initial begin : stimulus
        int                   mark;
        colourMemoryPkg::keyT wrongKey;
        resetApp   = 1'b1;
        nKey       = 4'hF;
        pixelReady = 1'b0;
        repeat (4) @(negedge clock);
        resetApp = 1'b0;

        mark = totalErrors();
        waitColour(16'hFFFF);
        assert (pixelStream.pixelWrite) else begin
            $display("[FAIL] pixelWrite expected 0x1 got 0x%h", pixelStream.pixelWrite);
            stimErrors++;
        end
        holdScreen(colourMemoryPkg::codeIntro, 0, 1'b0, 8);
        endTest("reset and intro", mark);

        // Random stalls, then a clean run to the frame wrap.
        mark = totalErrors();
        holdCount      = 0;
        colWrapCount   = 0;
        frameWrapCount = 0;
        readyRandom = 1'b1;
        stepCycles(3000);
        readyRandom = 1'b0;
        while (frameWrapCount == 0) stepCycle();
        assert (holdCount > 0 && colWrapCount > 0) else begin
            $display("Raster walk never stalled or never wrapped a column");
            stimErrors++;
        end
        endTest("raster pacing", mark);

        mark = totalErrors();
        readyRandom   = 1'b1;
        expectCode    = colourMemoryPkg::codeIntro;
        expectVisible = 1'b0;
        checkPixels   = 1'b1;
        checkSegs     = 1'b1;
        stepCycle();
        nKey = 4'b1010;
        stepCycles(5);
        nKey = 4'b0000;
        stepCycles(5);
        nKey = 4'hF;
        stepCycles(3);
        checkPixels = 1'b0;
        checkSegs   = 1'b0;
        pressKey(4'b0001);
        waitColour(16'h0000);
        endTest("key filter", mark);

        mark = totalErrors();
        collectRuns(3);
        replaySequence();
        checkWin(3);
        pressKey(4'b1000);
        collectRuns(4);
        replaySequence();
        checkWin(7);
        endTest("levels 1 and 2", mark);

        // Level 3 lost on its first entry.
        mark = totalErrors();
        pressKey(4'b0010);
        collectRuns(5);
        wrongKey = colourToKey(seqColours[0]);
        pressKey({wrongKey[2:0], wrongKey[3]});
        while (nSevenSeg0 == 7'h7F) stepCycle();
        stepCycles(3);
        readyRandom = 1'b0;
        holdScreen(colourMemoryPkg::codeGameOver, 7, 1'b1, frameCycles);
        assert (bannerCount > 0 && outsideCount > 0) else begin
            $display("Game-over frame did not cover both the banner and the background");
            stimErrors++;
        end
        readyRandom = 1'b1;
        pressKey(4'b0100);
        waitColour(16'hFFFF);
        holdScreen(colourMemoryPkg::codeIntro, 0, 1'b0, 8);
        endTest("game over", mark);

        $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors());
        if (testsFailed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- files.f
common/colourMemoryPkg.sv
hdl/rasterScanner.sv
game/gameController.sv
hdl/pixelComposer.sv
hdl/scoreDisplay.sv
hdl/colourMemoryTop.sv
tests/colourMemoryTb.sv

//--- run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it, and judges the run by its log.
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module colourMemoryTb \
    --Mdir obj_dir -o colourMemorySim &&
./obj_dir/colourMemorySim > sim.log 2>&1 ||
{ echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
